/* build.f */
hdl/dsp16_pkg.sv
hdl/dsp16_regs.sv
hdl/dsp16_sio_fsm.sv
hdl/dsp16_sio_timer.sv
hdl/dsp16_sio_shift.sv
hdl/dsp16_pio.sv
hdl/dsp16_periph.sv
verif/dsp16_periph_checker.sv
verif/dsp16_periph_tb.sv

/* run.sh */
#!/bin/sh
# Builds the DSP16 peripheral testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module dsp16_periph_tb -Mdir obj_dir -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vdsp16_periph_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    exit 1
fi
exit 0

/* verif/dsp16_periph_tb.sv */
//##########################################################################
// Testbench for the DSP16 peripherals: register bus, serial output, PIO
// Self-checking; the sdo monitor compares each word against a reference
//##########################################################################

`timescale 1ns/10ps

module dsp16_periph_tb import dsp16_pkg::*; ();

    localparam int CLK_HALF          = 20;
    localparam int CLK_PERIOD        = 2 * CLK_HALF;
    localparam int RESET_CYCLES      = 4;
    localparam int WORDS_PER_SETTING = 2;
    // Eight rate and order settings plus the buffered pair
    localparam int NUM_WORDS     = 8 * WORDS_PER_SETTING + 2;
    localparam int WORD_CYCLES   = 2 * DATA_W * int'(OCK_HALF[3]);
    localparam int MARGIN_CYCLES = 500;
    localparam int READ_LIMIT    = 4 * PIO_STROBE;

    logic     clk;
    logic     rst_n;
    logic     wr;
    logic     rd;
    reg_sel_t reg_sel;
    word_t    wr_data;
    word_t    rd_data;
    logic     rd_valid;
    logic     sdo;
    logic     ock;
    logic     old;
    logic     ose;
    logic     obe;
    word_t    ser_out;
    word_t    pbus_in;
    word_t    pbus_out;
    logic     pods_n;
    logic     pids_n;

    logic [31:0] rng_state;
    int          error_count;
    int          sent_words;
    word_t       exp_stream [NUM_WORDS];

    // Owned by the sdo monitor
    logic [BIT_CNT_W-1:0] rx_bit     = '0;
    word_t                rx_stream  = '0;
    int                   rx_words   = 0;
    int                   mon_errors = 0;

    dsp16_periph i_dsp16_periph (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .wr       ( wr       ),
        .rd       ( rd       ),
        .reg_sel  ( reg_sel  ),
        .wr_data  ( wr_data  ),
        .rd_data  ( rd_data  ),
        .rd_valid ( rd_valid ),
        .sdo      ( sdo      ),
        .ock      ( ock      ),
        .old      ( old      ),
        .ose      ( ose      ),
        .obe      ( obe      ),
        .ser_out  ( ser_out  ),
        .pbus_in  ( pbus_in  ),
        .pbus_out ( pbus_out ),
        .pods_n   ( pods_n   ),
        .pids_n   ( pids_n   )
    );

    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic random_word(output word_t w);
        rng_state = xorshift32(rng_state);
        w = rng_state[DATA_W-1:0];
    endtask

    // Bit i of the result is the i-th bit driven on sdo
    function automatic word_t serial_order(input word_t w, input logic msb_first);
        word_t s;
        for (int i = 0; i < DATA_W; i++) begin
            s[i] = msb_first ? w[DATA_W-1-i] : w[i];
        end
        return s;
    endfunction

    task automatic compare_word(input string name, input word_t exp, input word_t act,
                                inout int errors);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            error_count++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Called and returning on a falling edge
    task automatic bus_write(input reg_sel_t sel, input word_t data);
        wr      = 1'b1;
        reg_sel = sel;
        wr_data = data;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic wait_read_data(input string name, output word_t data);
        int waited;
        waited = 0;
        while (!rd_valid && waited < READ_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_valid) begin
            error_count++;
            $display("%s: rd_valid never came within %0d cycles", name, READ_LIMIT);
        end
        data = rd_data;
    endtask

    task automatic bus_read(input reg_sel_t sel, output word_t data);
        rd      = 1'b1;
        reg_sel = sel;
        @(negedge clk);
        rd = 1'b0;
        wait_read_data($sformatf("Read of register %0d", sel), data);
    endtask

    task automatic wait_for_ose(input string name, input int words);
        int waited;
        int limit;
        limit  = words * WORD_CYCLES + 20;
        waited = 0;
        while (!ose && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!ose) begin
            error_count++;
            $display("%s: serial port still busy after %0d cycles", name, limit);
        end
    endtask

    task automatic send_serial_word(input string name, input logic msb_first);
        word_t w;
        word_t status;
        random_word(w);
        exp_stream[sent_words] = serial_order(w, msb_first);
        sent_words++;
        bus_write(REG_SDX, w);
        compare_flag({name, " old"}, 1'b1, old);
        compare_flag({name, " ose"}, 1'b0, ose);
        compare_flag({name, " ock"}, 1'b0, ock);
        compare_flag({name, " first bit"}, exp_stream[sent_words - 1][0], sdo);
        // One word in flight and the buffer still empty
        bus_read(REG_SIOS, status);
        compare_word({name, " SIOS"}, 16'h0002, status, error_count);
        wait_for_ose(name, 1);
        compare_word({name, " ser_out"}, w, ser_out, error_count);
        compare_count({name, " words on sdo"}, sent_words, rx_words);
    endtask

    task automatic report_and_finish(input int timeouts);
        int total;
        total = error_count + mon_errors + timeouts;
        $display("Error count: %0d (bus and flags %0d, sdo monitor %0d, timeouts %0d)",
                 total, error_count, mon_errors, timeouts);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // Collect sdo at each ock rise and compare every full word
    always @(posedge ock) begin
        rx_stream[rx_bit] = sdo;
        if (&rx_bit) begin
            if (rx_words >= sent_words) begin
                mon_errors++;
                $display("Serial word %h appeared on sdo with no write pending", rx_stream);
            end else begin
                compare_word("sdo stream", exp_stream[rx_words], rx_stream, mon_errors);
            end
            rx_words++;
        end
        rx_bit = rx_bit + 1'b1;
    end

    initial begin
        #((NUM_WORDS * WORD_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the watchdog stopped the run before all tests ended");
        report_and_finish(1);
    end

    initial begin
        word_t      rdata;
        word_t      sioc_word;
        word_t      w1;
        word_t      w2;
        word_t      w3;
        logic [1:0] rate;
        logic       msb_first;
        int         low_cycles;
        clk         = 1'b0;
        rst_n       = 1'b0;
        wr          = 1'b0;
        rd          = 1'b0;
        reg_sel     = REG_SDX;
        wr_data     = '0;
        pbus_in     = '0;
        rng_state   = 32'hc460a036;
        error_count = 0;
        sent_words  = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Reset values and register readback
        compare_flag("reset pods_n", 1'b1, pods_n);
        compare_flag("reset pids_n", 1'b1, pids_n);
        compare_flag("reset ose", 1'b1, ose);
        compare_flag("reset obe", 1'b1, obe);
        compare_flag("reset old", 1'b0, old);
        compare_flag("reset ock", 1'b0, ock);
        compare_flag("reset sdo", 1'b0, sdo);
        compare_flag("reset rd_valid", 1'b0, rd_valid);
        compare_word("reset pbus_out", '0, pbus_out, error_count);
        compare_word("reset ser_out", '0, ser_out, error_count);
        bus_read(REG_SIOC, rdata);
        compare_word("reset SIOC", '0, rdata, error_count);
        bus_read(REG_SIOS, rdata);
        compare_word("idle SIOS", 16'h0003, rdata, error_count);
        bus_read(REG_SDX, rdata);
        compare_word("SDX read", '0, rdata, error_count);
        random_word(sioc_word);
        bus_write(REG_SIOC, sioc_word);
        bus_read(REG_SIOC, rdata);
        compare_word("SIOC readback", {{(DATA_W - SIOC_W){1'b0}}, sioc_word[SIOC_W-1:0]},
                     rdata, error_count);

        // Every rate in both bit orders
        for (int setting = 0; setting < 8; setting++) begin
            random_word(sioc_word);
            rate      = setting[1:0];
            msb_first = setting[2];
            bus_write(REG_SIOC, {sioc_word[DATA_W-1:SIOC_W], msb_first, rate});
            repeat (WORDS_PER_SETTING) begin
                send_serial_word($sformatf("rate %0d msb %0b", rate, msb_first), msb_first);
            end
        end

        // Back-to-back words; the third finds the buffer full
        random_word(sioc_word);
        msb_first = sioc_word[2];
        bus_write(REG_SIOC, sioc_word);
        random_word(w1);
        random_word(w2);
        random_word(w3);
        exp_stream[sent_words] = serial_order(w1, msb_first);
        exp_stream[sent_words + 1] = serial_order(w2, msb_first);
        sent_words = sent_words + 2;
        bus_write(REG_SDX, w1);
        bus_write(REG_SDX, w2);
        compare_flag("buffered obe", 1'b0, obe);
        compare_flag("buffered ose", 1'b0, ose);
        bus_write(REG_SDX, w3);
        compare_flag("dropped write obe", 1'b0, obe);
        wait_for_ose("buffered pair", 2);
        compare_word("buffered ser_out", w2, ser_out, error_count);
        compare_flag("drained obe", 1'b1, obe);
        compare_count("buffered words on sdo", sent_words, rx_words);

        // PDX write with a second write landing inside the strobe
        random_word(w1);
        random_word(w2);
        wr      = 1'b1;
        reg_sel = REG_PDX;
        wr_data = w1;
        @(negedge clk);
        wr_data    = w2;
        low_cycles = 0;
        while (!pods_n && low_cycles <= PIO_STROBE) begin
            compare_word("pdx write pbus_out", w1, pbus_out, error_count);
            low_cycles++;
            @(negedge clk);
            wr = 1'b0;
        end
        compare_count("pods_n low cycles", PIO_STROBE, low_cycles);
        repeat (2) @(negedge clk);
        compare_flag("pods_n after strobe", 1'b1, pods_n);
        compare_word("pbus_out after strobe", w1, pbus_out, error_count);

        // PDX read held for two cycles, the second is ignored
        random_word(w1);
        pbus_in = ~w1;
        rd      = 1'b1;
        reg_sel = REG_PDX;
        @(negedge clk);
        pbus_in    = w1;
        low_cycles = 0;
        while (!pids_n && low_cycles <= PIO_STROBE) begin
            low_cycles++;
            @(negedge clk);
            rd = 1'b0;
        end
        compare_count("pids_n low cycles", PIO_STROBE, low_cycles);
        wait_read_data("PDX read", rdata);
        compare_word("pdx read data", w1, rdata, error_count);
        repeat (2 * PIO_STROBE) begin
            @(negedge clk);
            compare_flag("no second rd_valid", 1'b0, rd_valid);
        end
        compare_flag("pids_n idle", 1'b1, pids_n);

        compare_count("words on sdo at end", sent_words, rx_words);
        report_and_finish(0);
    end

endmodule

/* verif/dsp16_periph_checker.sv */
//##########################################################################
// Concurrent assertions on the parallel strobes and serial output flags
// Bound into dsp16_periph at the end of this file
//##########################################################################

`timescale 1ns/10ps

module dsp16_periph_checker import dsp16_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic old,
    input logic ose,
    input logic obe,
    input logic pods_n,
    input logic pids_n
);

    int pods_low_cnt;
    int pids_low_cnt;

    // Low cycles seen so far in the current strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pods_low_cnt <= 0;
            pids_low_cnt <= 0;
        end else begin
            pods_low_cnt <= pods_n ? 0 : pods_low_cnt + 1;
            pids_low_cnt <= pids_n ? 0 : pids_low_cnt + 1;
        end
    end

    old_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) old |=> !old)
        else $error("old stayed high for more than one cycle");

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n) pods_n || pids_n)
        else $error("pods_n and pids_n low at the same time");

    pods_not_too_long: assert property (@(posedge clk) disable iff (!rst_n)
        !pods_n |-> pods_low_cnt < PIO_STROBE)
        else $error("pods_n low for too many cycles");

    pods_full_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pods_n) |-> pods_low_cnt == PIO_STROBE)
        else $error("pods_n low phase too short");

    pids_not_too_long: assert property (@(posedge clk) disable iff (!rst_n)
        !pids_n |-> pids_low_cnt < PIO_STROBE)
        else $error("pids_n low for too many cycles");

    pids_full_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pids_n) |-> pids_low_cnt == PIO_STROBE)
        else $error("pids_n low phase too short");

    // A full buffer only exists behind a word in flight
    buffer_needs_shift: assert property (@(posedge clk) disable iff (!rst_n) !obe |-> !ose)
        else $error("obe low while ose high");

endmodule

bind dsp16_periph dsp16_periph_checker i_checker (
    .clk    ( clk    ),
    .rst_n  ( rst_n  ),
    .old    ( old    ),
    .ose    ( ose    ),
    .obe    ( obe    ),
    .pods_n ( pods_n ),
    .pids_n ( pids_n )
);

/* hdl/dsp16_periph.sv */
//##########################################################################
// DSP16 peripheral top level: register decoder, serial output and PIO
//##########################################################################

`timescale 1ns/10ps

module dsp16_periph import dsp16_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    // CPU register bus
    input  logic     wr,
    input  logic     rd,
    input  reg_sel_t reg_sel,
    input  word_t    wr_data,
    output word_t    rd_data,
    output logic     rd_valid,
    // Serial output
    output logic     sdo,
    output logic     ock,
    output logic     old,
    output logic     ose,
    output logic     obe,
    output word_t    ser_out,
    // Parallel port
    input  word_t    pbus_in,
    output word_t    pbus_out,
    output logic     pods_n,
    output logic     pids_n
);

    logic       sdx_wr;
    logic       pdx_wr;
    logic       pdx_rd;
    logic [1:0] sioc_rate;
    logic       sioc_msb;
    logic       pio_busy;
    logic       pio_done;
    word_t      pdx_in;

    // Serial control between FSM, timer and shifter
    logic       load_shift;
    logic       load_buf;
    logic       shift_run;
    logic       timer_start;
    logic       bit_edge;
    logic       last_bit;

    dsp16_regs u_regs (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .wr        ( wr        ),
        .rd        ( rd        ),
        .reg_sel   ( reg_sel   ),
        .wr_data   ( wr_data   ),
        .rd_data   ( rd_data   ),
        .rd_valid  ( rd_valid  ),
        .ose       ( ose       ),
        .obe       ( obe       ),
        .pio_busy  ( pio_busy  ),
        .pio_done  ( pio_done  ),
        .pdx_in    ( pdx_in    ),
        .sdx_wr    ( sdx_wr    ),
        .pdx_wr    ( pdx_wr    ),
        .pdx_rd    ( pdx_rd    ),
        .sioc_rate ( sioc_rate ),
        .sioc_msb  ( sioc_msb  )
    );

    dsp16_sio_fsm u_sio_fsm (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .sdx_wr      ( sdx_wr      ),
        .bit_edge    ( bit_edge    ),
        .last_bit    ( last_bit    ),
        .old         ( old         ),
        .ose         ( ose         ),
        .obe         ( obe         ),
        .load_shift  ( load_shift  ),
        .load_buf    ( load_buf    ),
        .shift_run   ( shift_run   ),
        .timer_start ( timer_start )
    );

    dsp16_sio_timer u_sio_timer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .timer_start ( timer_start ),
        .shift_run   ( shift_run   ),
        .sioc_rate   ( sioc_rate   ),
        .ock         ( ock         ),
        .bit_edge    ( bit_edge    ),
        .last_bit    ( last_bit    )
    );

    dsp16_sio_shift u_sio_shift (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .load_shift ( load_shift ),
        .load_buf   ( load_buf   ),
        .bit_edge   ( bit_edge   ),
        .last_bit   ( last_bit   ),
        .sioc_msb   ( sioc_msb   ),
        .wr_data    ( wr_data    ),
        .sdo        ( sdo        ),
        .ser_out    ( ser_out    )
    );

    dsp16_pio u_pio (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pdx_wr   ( pdx_wr   ),
        .pdx_rd   ( pdx_rd   ),
        .wr_data  ( wr_data  ),
        .pbus_in  ( pbus_in  ),
        .pbus_out ( pbus_out ),
        .pdx_in   ( pdx_in   ),
        .pods_n   ( pods_n   ),
        .pids_n   ( pids_n   ),
        .pio_busy ( pio_busy ),
        .pio_done ( pio_done )
    );

endmodule

/* hdl/dsp16_pio.sv */
//##########################################################################
// Parallel I/O port: output register, strobe timing and input capture
// One strobe counter is shared by the write and the read direction
//##########################################################################

`timescale 1ns/10ps

module dsp16_pio import dsp16_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  pdx_wr,
    input  logic  pdx_rd,
    input  word_t wr_data,
    input  word_t pbus_in,
    output word_t pbus_out,
    output word_t pdx_in,
    output logic  pods_n,
    output logic  pids_n,
    output logic  pio_busy,
    output logic  pio_done
);

    logic [$clog2(PIO_STROBE)-1:0] strobe_cnt;
    logic                          strobe_last;

    assign pio_busy    = !pods_n || !pids_n;
    assign strobe_last = pio_busy && (int'(strobe_cnt) == PIO_STROBE - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pbus_out   <= '0;
            pods_n     <= 1'b1;
            pids_n     <= 1'b1;
            strobe_cnt <= '0;
            pio_done   <= 1'b0;
        end else begin
            pio_done <= !pids_n && strobe_last;
            if (pdx_wr) begin
                pbus_out   <= wr_data;
                pods_n     <= 1'b0;
                strobe_cnt <= '0;
            end else if (pdx_rd) begin
                pids_n     <= 1'b0;
                strobe_cnt <= '0;
            end else if (strobe_last) begin
                pods_n <= 1'b1;
                pids_n <= 1'b1;
            end else if (pio_busy) begin
                strobe_cnt <= strobe_cnt + 1'b1;
            end
        end
    end

    // Sample the input bus in the final low cycle of pids_n
    always_ff @(posedge clk) begin
        if (!pids_n && strobe_last) begin
            pdx_in <= pbus_in;
        end
    end

endmodule

/* hdl/dsp16_sio_shift.sv */
//##########################################################################
// Serial output data path: buffer word, shift register and ser_out copy
//##########################################################################

`timescale 1ns/10ps

module dsp16_sio_shift import dsp16_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load_shift,
    input  logic  load_buf,
    input  logic  bit_edge,
    input  logic  last_bit,
    input  logic  sioc_msb,
    input  word_t wr_data,
    output logic  sdo,
    output word_t ser_out
);

    word_t buf_q;
    word_t word_q;
    word_t shift_q;
    word_t load_word;
    logic  msb_q;

    // Bypass the buffer when the write starts a word directly
    assign load_word = load_buf ? wr_data : buf_q;
    assign sdo       = msb_q ? shift_q[DATA_W-1] : shift_q[0];

    always_ff @(posedge clk) begin
        if (load_buf) begin
            buf_q <= wr_data;
        end
        if (load_shift) begin
            word_q <= load_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q <= '0;
            msb_q   <= 1'b0;
            ser_out <= '0;
        end else begin
            if (load_shift) begin
                shift_q <= load_word;
                msb_q   <= sioc_msb;
            end else if (bit_edge) begin
                shift_q <= msb_q ? {shift_q[DATA_W-2:0], 1'b0} : {1'b0, shift_q[DATA_W-1:1]};
            end
            if (bit_edge && last_bit) begin
                ser_out <= word_q;
            end
        end
    end

endmodule

/* hdl/dsp16_sio_timer.sv */
//##########################################################################
// Bit timing for the serial output: ock generation and 16-bit count
//##########################################################################

`timescale 1ns/10ps

module dsp16_sio_timer import dsp16_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       timer_start,
    input  logic       shift_run,
    input  logic [1:0] sioc_rate,
    output logic       ock,
    output logic       bit_edge,
    output logic       last_bit
);

    logic [1:0]           rate_q;
    ock_half_t            half_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 half_end;

    assign half_end = (half_cnt == OCK_HALF[rate_q] - 1'b1);
    // End of the high phase closes a bit
    assign bit_edge = shift_run && ock && half_end;
    assign last_bit = &bit_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rate_q   <= '0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            ock      <= 1'b0;
        end else if (timer_start) begin
            rate_q   <= sioc_rate;
            half_cnt <= '0;
            bit_cnt  <= '0;
            ock      <= 1'b0;
        end else if (shift_run) begin
            if (half_end) begin
                half_cnt <= '0;
                ock      <= !ock;
                if (ock) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/dsp16_sio_fsm.sv */
//##########################################################################
// Serial output control: idle/shifting state, one-word buffer and flags
// Chooses whether a data write goes to the shifter, the buffer or nowhere
//##########################################################################

`timescale 1ns/10ps

module dsp16_sio_fsm import dsp16_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic sdx_wr,
    input  logic bit_edge,
    input  logic last_bit,
    output logic old,
    output logic ose,
    output logic obe,
    output logic load_shift,
    output logic load_buf,
    output logic shift_run,
    output logic timer_start
);

    logic shifting;
    logic buf_full;
    logic word_end;

    assign word_end = shifting && bit_edge && last_bit;

    // load_buf together with load_shift means wr_data goes straight to the shifter
    always_comb begin
        load_shift = 1'b0;
        load_buf   = 1'b0;
        if (!shifting) begin
            load_shift = sdx_wr;
            load_buf   = sdx_wr;
        end else if (word_end) begin
            if (buf_full) begin
                load_shift = 1'b1;
            end else if (sdx_wr) begin
                load_shift = 1'b1;
                load_buf   = 1'b1;
            end
        end else if (sdx_wr && !buf_full) begin
            load_buf = 1'b1;
        end
    end

    assign timer_start = load_shift;
    assign shift_run   = shifting;
    assign ose         = !shifting;
    assign obe         = !buf_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shifting <= 1'b0;
            buf_full <= 1'b0;
            old      <= 1'b0;
        end else begin
            old <= load_shift;
            if (load_shift) begin
                shifting <= 1'b1;
            end else if (word_end) begin
                shifting <= 1'b0;
            end
            // Buffer drains only when the next word starts
            if (load_buf && !load_shift) begin
                buf_full <= 1'b1;
            end else if (word_end && buf_full) begin
                buf_full <= 1'b0;
            end
        end
    end

endmodule

/* hdl/dsp16_regs.sv */
//##########################################################################
// CPU register decoder: write strobes, SIOC register and registered reads
//##########################################################################

`timescale 1ns/10ps

module dsp16_regs import dsp16_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr,
    input  logic       rd,
    input  reg_sel_t   reg_sel,
    input  word_t      wr_data,
    output word_t      rd_data,
    output logic       rd_valid,
    input  logic       ose,
    input  logic       obe,
    input  logic       pio_busy,
    input  logic       pio_done,
    input  word_t      pdx_in,
    output logic       sdx_wr,
    output logic       pdx_wr,
    output logic       pdx_rd,
    output logic [1:0] sioc_rate,
    output logic       sioc_msb
);

    logic [SIOC_W-1:0] sioc_q;
    logic              rd_hit;
    word_t             rd_word;

    // PDX accesses are dropped while a strobe runs
    assign sdx_wr = wr && (reg_sel == REG_SDX);
    assign pdx_wr = wr && (reg_sel == REG_PDX) && !pio_busy;
    assign pdx_rd = rd && !wr && (reg_sel == REG_PDX) && !pio_busy;

    assign sioc_rate = sioc_q[1:0];
    assign sioc_msb  = sioc_q[2];

    // Immediate reads; PDX answers later through pio_done
    always_comb begin
        rd_hit  = 1'b0;
        rd_word = '0;
        if (pio_done) begin
            rd_hit  = 1'b1;
            rd_word = pdx_in;
        end else if (rd) begin
            case (reg_sel)
                REG_SDX: rd_hit = 1'b1;
                REG_SIOC: begin
                    rd_hit  = 1'b1;
                    rd_word = {{(DATA_W - SIOC_W){1'b0}}, sioc_q};
                end
                REG_SIOS: begin
                    rd_hit  = 1'b1;
                    rd_word = {{(DATA_W - 2){1'b0}}, obe, ose};
                end
                default: rd_hit = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sioc_q   <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_hit;
            if (wr && (reg_sel == REG_SIOC)) begin
                sioc_q <= wr_data[SIOC_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hit) begin
            rd_data <= rd_word;
        end
    end

endmodule

/* hdl/dsp16_pkg.sv */
//##########################################################################
// Shared widths, register codes and timing tables for the DSP16 peripherals
// Imported by every RTL module of the serial and parallel ports
//##########################################################################

package dsp16_pkg;

    // Data path widths
    localparam int DATA_W    = 16;
    localparam int BIT_CNT_W = 4;
    localparam int SIOC_W    = 3;

    // Cycles a parallel strobe stays low
    localparam int PIO_STROBE = 4;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [2:0]        reg_sel_t;

    // Register codes on the CPU bus
    localparam reg_sel_t REG_SDX  = 3'd0;
    localparam reg_sel_t REG_SIOC = 3'd1;
    localparam reg_sel_t REG_SIOS = 3'd2;
    localparam reg_sel_t REG_PDX  = 3'd3;

    // Wide enough to hold the largest half-period
    typedef logic [4:0] ock_half_t;

    // Half-period of ock in clk cycles, indexed by SIOC[1:0]
    localparam ock_half_t OCK_HALF [4] = '{
        5'd2,
        5'd4,
        5'd8,
        5'd16
    };

endpackage
